// File: Makefile
# Verilator flow for the I3C target front end

VERILATOR ?= verilator
TOP       ?= tb_i3c_target
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= All tests passed!

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Exit status comes from the search for the pass line
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: i3c_addr_receiver.sv
// *************************************************************************
// I3C/I2C address receiver
// Shifts in the address byte after each START, checks it against the
// static and broadcast addresses and drives the open-drain ACK
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

module i3c_addr_receiver (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 start_i,
  input  logic                                 rstart_i,
  input  logic                                 stop_i,
  input  logic                                 scl_posedge_i,
  input  logic                                 scl_negedge_i,
  input  logic                                 sda_value_i,
  input  logic                                 ack_en_i,
  input  logic [i3c_target_pkg::AddrWidth-1:0] static_addr_i,
  output logic                                 sda_o,
  output logic                                 bus_addr_valid_o,
  output logic                                 event_valid_o,
  output logic [i3c_target_pkg::ByteWidth-1:0] bus_addr_o,
  output i3c_target_pkg::addr_event_t          event_data_o
);
  import i3c_target_pkg::*;

  logic                         armed;
  logic [$clog2(ByteWidth)-1:0] bit_cnt;
  logic [ByteWidth-1:0]         shift_q;
  logic [ByteWidth-1:0]         shift_next;
  logic                         last_bit;
  logic                         addr_match;
  logic                         ack_pending;
  logic                         ack_drive;

  // MSB first on the bus
  assign shift_next = {shift_q[ByteWidth-2:0], sda_value_i};
  assign last_bit   = &bit_cnt;
  assign addr_match = (shift_next[ByteWidth-1:1] == static_addr_i) ||
                      (shift_next[ByteWidth-1:1] == BroadcastAddr);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      armed            <= 1'b0;
      bit_cnt          <= '0;
      ack_pending      <= 1'b0;
      ack_drive        <= 1'b0;
      bus_addr_valid_o <= 1'b0;
      event_valid_o    <= 1'b0;
    end else begin
      bus_addr_valid_o <= 1'b0;
      event_valid_o    <= 1'b0;
      if (stop_i) begin
        armed       <= 1'b0;
        ack_pending <= 1'b0;
        ack_drive   <= 1'b0;
      end else if (start_i || rstart_i) begin
        armed       <= 1'b1;
        bit_cnt     <= '0;
        ack_pending <= 1'b0;
        ack_drive   <= 1'b0;
      end else begin
        if (armed && scl_posedge_i) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (last_bit) begin
            // Only the first byte of a transfer is an address
            armed            <= 1'b0;
            bus_addr_valid_o <= 1'b1;
            event_valid_o    <= 1'b1;
            ack_pending      <= addr_match & ack_en_i;
          end
        end
        // ACK slot spans the 9th SCL low and high phase
        if (scl_negedge_i) begin
          if (ack_pending) begin
            ack_pending <= 1'b0;
            ack_drive   <= 1'b1;
          end else begin
            ack_drive <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (armed && scl_posedge_i) begin
      shift_q <= shift_next;
      if (last_bit) begin
        bus_addr_o             <= shift_next;
        event_data_o.addr_byte <= shift_next;
        event_data_o.match     <= addr_match;
      end
    end
  end

  // Open drain, only ever pulls low
  assign sda_o = ~ack_drive;

  ack_on_match_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(sda_o) |-> $past(scl_negedge_i) && event_data_o.match && !armed);

endmodule

`default_nettype wire

// File: i3c_bus_monitor.sv
// *************************************************************************
// I3C/I2C bus monitor
// Synchronizes SCL and SDA and flags START, repeated START, STOP and
// SCL edges as single-cycle pulses
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

module i3c_bus_monitor (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic start_o,
  output logic rstart_o,
  output logic stop_o,
  output logic scl_posedge_o,
  output logic scl_negedge_o,
  output logic sda_value_o,
  output logic xfer_active_o
);
  import i3c_target_pkg::*;

  logic [SyncStages-1:0] scl_sync;
  logic [SyncStages-1:0] sda_sync;
  logic                  scl_cur;
  logic                  sda_cur;
  logic                  scl_prev;
  logic                  sda_prev;
  logic                  scl_high;
  logic                  start_cond;
  logic                  stop_cond;
  logic                  xfer_active;

  // Idle bus is high, so the chain resets to ones
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_sync <= '1;
      sda_sync <= '1;
    end else begin
      scl_sync <= {scl_sync[SyncStages-2:0], scl_i};
      sda_sync <= {sda_sync[SyncStages-2:0], sda_i};
    end
  end

  assign scl_cur = scl_sync[SyncStages-1];
  assign sda_cur = sda_sync[SyncStages-1];

  // SCL high over both samples, so an SDA move is a bus condition
  assign scl_high   = scl_cur & scl_prev;
  assign start_cond = scl_high & sda_prev & ~sda_cur;
  assign stop_cond  = scl_high & ~sda_prev & sda_cur;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      scl_prev      <= 1'b1;
      sda_prev      <= 1'b1;
      start_o       <= 1'b0;
      rstart_o      <= 1'b0;
      stop_o        <= 1'b0;
      scl_posedge_o <= 1'b0;
      scl_negedge_o <= 1'b0;
      xfer_active   <= 1'b0;
    end else begin
      scl_prev      <= scl_cur;
      sda_prev      <= sda_cur;
      start_o       <= start_cond & ~xfer_active;
      rstart_o      <= start_cond & xfer_active;
      stop_o        <= stop_cond;
      scl_posedge_o <= scl_cur & ~scl_prev;
      scl_negedge_o <= ~scl_cur & scl_prev;
      if (start_cond) begin
        xfer_active <= 1'b1;
      end else if (stop_cond) begin
        xfer_active <= 1'b0;
      end
    end
  end

  // Edge register doubles as the sampled SDA level
  assign sda_value_o   = sda_prev;
  assign xfer_active_o = xfer_active;

  start_stop_excl_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(start_o && stop_o));

  rstart_in_xfer_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rstart_o |-> xfer_active && $past(xfer_active));

endmodule

`default_nettype wire

// File: i3c_rx_event_queue.sv
// *************************************************************************
// Receive event queue
// Small circular FIFO of address events towards the host, with a
// saturating count of events dropped while full
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

module i3c_rx_event_queue (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     event_valid_i,
  input  i3c_target_pkg::addr_event_t              event_data_i,
  input  logic                                     rx_desc_wready_i,
  output logic                                     rx_desc_wvalid_o,
  output i3c_target_pkg::addr_event_t              rx_desc_wdata_o,
  output logic [i3c_target_pkg::EventCntWidth-1:0] dropped_cnt_o
);
  import i3c_target_pkg::*;

  addr_event_t                        mem [EventQueueDepth];
  logic [$clog2(EventQueueDepth)-1:0] wr_ptr;
  logic [$clog2(EventQueueDepth)-1:0] rd_ptr;
  logic [$bits(EventQueueDepth)-1:0]  fill;
  logic                               full;
  logic                               push;
  logic                               pop;

  assign full = (fill == EventQueueDepth);
  assign pop  = rx_desc_wvalid_o & rx_desc_wready_i;
  // A full queue still takes a write when an entry leaves
  assign push = event_valid_i & (~full | pop);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill          <= '0;
      dropped_cnt_o <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !push) begin
        fill <= fill - 1'b1;
      end
      if (event_valid_i && !push && !(&dropped_cnt_o)) begin
        dropped_cnt_o <= dropped_cnt_o + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr] <= event_data_i;
  end

  assign rx_desc_wvalid_o = (fill != '0);
  assign rx_desc_wdata_o  = mem[rd_ptr];

  fill_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fill <= EventQueueDepth);

  wdata_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rx_desc_wvalid_o && !rx_desc_wready_i |=> rx_desc_wvalid_o && $stable(rx_desc_wdata_o));

endmodule

`default_nettype wire

// File: i3c_target_frontend.sv
// *************************************************************************
// I3C target front end top level
// Bus monitor, address receiver and receive event queue
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

module i3c_target_frontend (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                                     scl_i,
  input  logic                                     sda_i,
  input  logic                                     ack_en_i,
  input  logic                                     rx_desc_wready_i,
  input  logic [i3c_target_pkg::AddrWidth-1:0]     static_addr_i,
  output logic                                     sda_o,
  output logic                                     bus_start_o,
  output logic                                     bus_rstart_o,
  output logic                                     bus_stop_o,
  output logic                                     bus_scl_posedge_o,
  output logic                                     bus_addr_valid_o,
  output logic                                     rx_desc_wvalid_o,
  output logic [i3c_target_pkg::ByteWidth-1:0]     bus_addr_o,
  output i3c_target_pkg::addr_event_t              rx_desc_wdata_o,
  output logic [i3c_target_pkg::EventCntWidth-1:0] dropped_cnt_o
);
  import i3c_target_pkg::*;

  logic        scl_negedge;
  logic        sda_value;
  logic        event_valid;
  addr_event_t event_data;

  i3c_bus_monitor u_bus_monitor (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .scl_i         (scl_i),
    .sda_i         (sda_i),
    .start_o       (bus_start_o),
    .rstart_o      (bus_rstart_o),
    .stop_o        (bus_stop_o),
    .scl_posedge_o (bus_scl_posedge_o),
    .scl_negedge_o (scl_negedge),
    .sda_value_o   (sda_value),
    .xfer_active_o ()
  );

  i3c_addr_receiver u_addr_receiver (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .start_i          (bus_start_o),
    .rstart_i         (bus_rstart_o),
    .stop_i           (bus_stop_o),
    .scl_posedge_i    (bus_scl_posedge_o),
    .scl_negedge_i    (scl_negedge),
    .sda_value_i      (sda_value),
    .ack_en_i         (ack_en_i),
    .static_addr_i    (static_addr_i),
    .sda_o            (sda_o),
    .bus_addr_valid_o (bus_addr_valid_o),
    .event_valid_o    (event_valid),
    .bus_addr_o       (bus_addr_o),
    .event_data_o     (event_data)
  );

  i3c_rx_event_queue u_rx_event_queue (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .event_valid_i    (event_valid),
    .event_data_i     (event_data),
    .rx_desc_wready_i (rx_desc_wready_i),
    .rx_desc_wvalid_o (rx_desc_wvalid_o),
    .rx_desc_wdata_o  (rx_desc_wdata_o),
    .dropped_cnt_o    (dropped_cnt_o)
  );

endmodule

`default_nettype wire

// File: i3c_target_pkg.sv
// *************************************************************************
// I3C target front end shared definitions
// Bus framing constants, synchronizer depth, event queue sizing and the
// address event carried from the receiver to the host queue
// *************************************************************************
`default_nettype none

package i3c_target_pkg;

  // Address and byte framing
  localparam int unsigned AddrWidth = 7;
  localparam int unsigned ByteWidth = 8;

  // Every I3C target answers the broadcast address
  localparam logic [AddrWidth-1:0] BroadcastAddr = 7'h7E;

  // Flops on SCL and SDA before edge detection
  localparam int unsigned SyncStages = 2;

  // Entries in the receive event queue, sized to the fill count
  localparam logic [2:0] EventQueueDepth = 3'd4;

  // Saturating dropped-event counter
  localparam int unsigned EventCntWidth = 8;

  // One queue entry
  // Address in the upper bits of addr_byte, RnW in bit 0
  typedef struct packed {
    logic [ByteWidth-1:0] addr_byte;
    logic                 match;
  } addr_event_t;

endpackage

`default_nettype wire

// File: sources.f
i3c_target_pkg.sv
i3c_bus_monitor.sv
i3c_addr_receiver.sv
i3c_rx_event_queue.sv
i3c_target_frontend.sv
tb_event_checker.sv
tb_i3c_target.sv

// File: tb_event_checker.sv
// *************************************************************************
// Checker for the I3C target front end testbench
// Holds the expected address events and compares bus pulses, address
// capture, ACK and queue output against them
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_event_checker (
  input logic                                 clk_i,
  input logic                                 rst_n_i,
  input logic                                 sda_i,
  input logic                                 start_i,
  input logic                                 rstart_i,
  input logic                                 stop_i,
  input logic                                 scl_posedge_i,
  input logic                                 addr_valid_i,
  input logic [i3c_target_pkg::ByteWidth-1:0] addr_i,
  input logic                                 wvalid_i,
  input logic                                 wready_i,
  input i3c_target_pkg::addr_event_t          wdata_i,
  input logic [i3c_target_pkg::AddrWidth-1:0] static_addr_i
);
  import i3c_target_pkg::*;

  int          error_cnt = 0;
  int          check_cnt = 0;
  int          start_cnt = 0;
  int          rstart_cnt = 0;
  int          stop_cnt = 0;
  int          scl_rise_cnt = 0;
  logic [7:0]  addr_q[$];
  logic        ack_q[$];
  string       addr_name_q[$];
  addr_event_t event_q[$];
  string       event_name_q[$];
  int          bit_pos;
  logic        cur_ack;
  logic        low_flagged;
  string       cur_name;

  // Static or broadcast address matches, RnW plays no part
  function automatic addr_event_t expected_event(logic [7:0] sent, logic [6:0] static_addr);
    addr_event_t ev;
    ev.addr_byte = sent;
    ev.match     = (sent[7:1] == static_addr) || (sent[7:1] == BroadcastAddr);
    return ev;
  endfunction

  function automatic void expect_addr(logic [7:0] sent, logic ack_en, string name,
                                      logic delivered);
    addr_event_t ev;
    ev = expected_event(sent, static_addr_i);
    addr_q.push_back(sent);
    ack_q.push_back(ev.match & ack_en);
    addr_name_q.push_back(name);
    if (delivered) begin
      event_q.push_back(ev);
      event_name_q.push_back(name);
    end
  endfunction

  function automatic void check_equal(string name, int expected, int actual);
    check_cnt++;
    if (expected != actual) begin
      error_cnt++;
      $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    end
  endfunction

  function automatic void report_error(string what);
    error_cnt++;
    $display("ERROR: %s", what);
  endfunction

  function automatic int pending();
    return event_q.size();
  endfunction

  always @(posedge clk_i) begin
    if (rst_n_i && start_i) start_cnt++;
    if (rst_n_i && rstart_i) rstart_cnt++;
    if (rst_n_i && stop_i) stop_cnt++;
    if (rst_n_i && scl_posedge_i) scl_rise_cnt++;
  end

  // Address capture and the ACK slot share the bit position
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      bit_pos     = 0;
      cur_ack     = 1'b0;
      low_flagged = 1'b0;
    end else begin
      if (addr_valid_i) begin
        if (addr_q.size() == 0) begin
          report_error("address captured although no address byte was sent");
        end else begin
          cur_name = addr_name_q.pop_front();
          cur_ack  = ack_q.pop_front();
          check_equal({"address ", cur_name}, int'(addr_q.pop_front()), int'(addr_i));
        end
      end
      // 9th SCL rise
      if (scl_posedge_i && bit_pos == 8) begin
        check_equal({"ack ", cur_name}, int'(!cur_ack), int'(sda_i));
      end
      if (!sda_i && !(cur_ack && (bit_pos == 8 || bit_pos == 9)) && !low_flagged) begin
        report_error("sda_o pulled low outside an ACK slot");
        low_flagged = 1'b1;
      end
      if (start_i || rstart_i || stop_i) begin
        bit_pos     = 0;
        cur_ack     = 1'b0;
        low_flagged = 1'b0;
      end else if (scl_posedge_i) begin
        bit_pos++;
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_n_i && wvalid_i && wready_i) begin
      if (event_q.size() == 0) begin
        report_error("receive queue delivered an entry that was never expected");
      end else begin
        check_equal({"queue ", event_name_q.pop_front()}, int'(event_q.pop_front()),
                    int'(wdata_i));
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_i3c_target.sv
// *************************************************************************
// Testbench for the I3C target front end
// Bit-bangs START, address bytes, repeated START and STOP on an
// open-drain bus model and feeds the expected events to the checker
// *************************************************************************
`timescale 1ns/100ps
`default_nettype none

module tb_i3c_target;
  import i3c_target_pkg::*;

  localparam int HalfBit = 8;
  localparam int DriveDelay = 2;
  localparam logic [AddrWidth-1:0] StaticAddr = 7'h2A;

  logic                     clk;
  logic                     rst_n;
  logic                     scl_drv;
  logic                     sda_drv;
  logic                     sda_line;
  logic                     dut_sda;
  logic                     ack_en;
  logic                     wready;
  logic [AddrWidth-1:0]     static_addr;
  logic                     bus_start;
  logic                     bus_rstart;
  logic                     bus_stop;
  logic                     scl_posedge;
  logic                     addr_valid;
  logic                     wvalid;
  logic [ByteWidth-1:0]     bus_addr;
  addr_event_t              wdata;
  logic [EventCntWidth-1:0] dropped_cnt;
  logic [31:0]              lcg_state;
  int                       n_start;
  int                       n_rstart;
  int                       n_stop;
  int                       n_scl_rise;

  // Open drain, either side pulls the line low
  assign sda_line = sda_drv & dut_sda;

  i3c_target_frontend dut_i (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .scl_i             (scl_drv),
    .sda_i             (sda_line),
    .ack_en_i          (ack_en),
    .rx_desc_wready_i  (wready),
    .static_addr_i     (static_addr),
    .sda_o             (dut_sda),
    .bus_start_o       (bus_start),
    .bus_rstart_o      (bus_rstart),
    .bus_stop_o        (bus_stop),
    .bus_scl_posedge_o (scl_posedge),
    .bus_addr_valid_o  (addr_valid),
    .rx_desc_wvalid_o  (wvalid),
    .bus_addr_o        (bus_addr),
    .rx_desc_wdata_o   (wdata),
    .dropped_cnt_o     (dropped_cnt)
  );

  tb_event_checker u_checker (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .sda_i         (dut_sda),
    .start_i       (bus_start),
    .rstart_i      (bus_rstart),
    .stop_i        (bus_stop),
    .scl_posedge_i (scl_posedge),
    .addr_valid_i  (addr_valid),
    .addr_i        (bus_addr),
    .wvalid_i      (wvalid),
    .wready_i      (wready),
    .wdata_i       (wdata),
    .static_addr_i (static_addr)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic wait_clks(int n);
    repeat (n) @(posedge clk);
    #DriveDelay;
  endtask

  task automatic send_start();
    sda_drv = 1'b0;
    n_start++;
    wait_clks(HalfBit);
    scl_drv = 1'b0;
  endtask

  task automatic send_rstart();
    wait_clks(2);
    sda_drv = 1'b1;
    wait_clks(HalfBit - 2);
    scl_drv = 1'b1;
    n_scl_rise++;
    wait_clks(HalfBit);
    sda_drv = 1'b0;
    n_rstart++;
    wait_clks(HalfBit);
    scl_drv = 1'b0;
  endtask

  // MSB first, 9th bit left released for the ACK
  task automatic send_byte(logic [7:0] data);
    logic [8:0] bits;
    bits = {data, 1'b1};
    repeat (9) begin
      wait_clks(2);
      sda_drv = bits[8];
      bits    = bits << 1;
      wait_clks(HalfBit - 2);
      scl_drv = 1'b1;
      n_scl_rise++;
      wait_clks(HalfBit);
      scl_drv = 1'b0;
    end
  endtask

  task automatic send_stop();
    wait_clks(2);
    sda_drv = 1'b0;
    wait_clks(HalfBit - 2);
    scl_drv = 1'b1;
    n_scl_rise++;
    wait_clks(HalfBit);
    sda_drv = 1'b1;
    n_stop++;
    wait_clks(HalfBit);
  endtask

  task automatic send_addr(logic [7:0] addr, string name, logic delivered);
    u_checker.expect_addr(addr, ack_en, name, delivered);
    send_byte(addr);
  endtask

  task automatic addr_xfer(logic [7:0] addr, string name, logic delivered);
    send_start();
    send_addr(addr, name, delivered);
    send_stop();
  endtask

  task automatic wait_drain(string name);
    int cycles;
    cycles = 0;
    while (u_checker.pending() != 0 && cycles < 200) begin
      @(posedge clk);
      #DriveDelay;
      cycles++;
    end
    if (u_checker.pending() != 0) begin
      u_checker.report_error({"timeout, receive queue did not drain in ", name});
    end
  endtask

  function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // About half of the picks hit the static or the broadcast address
  function automatic logic [7:0] pick_addr();
    lcg_state = lcg_next(lcg_state);
    if (!lcg_state[31]) return lcg_state[23:16];
    return {lcg_state[30] ? static_addr : BroadcastAddr, lcg_state[16]};
  endfunction

  initial begin
    rst_n       = 1'b0;
    scl_drv     = 1'b1;
    sda_drv     = 1'b1;
    ack_en      = 1'b1;
    wready      = 1'b1;
    static_addr = StaticAddr;
    lcg_state   = 32'h64a010a6;
    n_start     = 0;
    n_rstart    = 0;
    n_stop      = 0;
    n_scl_rise  = 0;
    wait_clks(3);
    rst_n = 1'b1;
    wait_clks(HalfBit);

    for (int i = 0; i < 12; i++) begin
      lcg_state = lcg_next(lcg_state);
      ack_en    = lcg_state[29];
      addr_xfer(pick_addr(), "random", 1'b1);
    end
    ack_en = 1'b0;
    addr_xfer({StaticAddr, 1'b0}, "ack disabled", 1'b1);
    ack_en = 1'b1;
    addr_xfer(8'h22, "no match", 1'b1);

    wready = 1'b0;
    for (int i = 0; i < 3; i++) begin
      addr_xfer(pick_addr(), "backpressure", 1'b1);
    end
    wready = 1'b1;
    wait_drain("backpressure");

    // Depth is four, the last two are dropped
    wready = 1'b0;
    for (int i = 0; i < 6; i++) begin
      addr_xfer(pick_addr(), "overflow", i < 4);
    end
    u_checker.check_equal("overflow dropped count", 2, int'(dropped_cnt));
    wready = 1'b1;
    wait_drain("overflow");

    // Data bytes look like matching addresses but must not queue
    send_start();
    send_addr({StaticAddr, 1'b0}, "rstart first", 1'b1);
    send_byte({StaticAddr, 1'b1});
    send_rstart();
    send_addr({BroadcastAddr, 1'b1}, "rstart second", 1'b1);
    send_byte({BroadcastAddr, 1'b1});
    send_stop();
    wait_drain("rstart");

    u_checker.check_equal("start count", n_start, u_checker.start_cnt);
    u_checker.check_equal("rstart count", n_rstart, u_checker.rstart_cnt);
    u_checker.check_equal("stop count", n_stop, u_checker.stop_cnt);
    u_checker.check_equal("scl rise count", n_scl_rise, u_checker.scl_rise_cnt);
    u_checker.check_equal("unseen addresses", 0, u_checker.addr_q.size());
    u_checker.check_equal("undelivered events", 0, u_checker.pending());
    $display("Checks run: %0d, errors: %0d", u_checker.check_cnt, u_checker.error_cnt);
    if (u_checker.error_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
